// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_prbs_test_top \
		-f build.f -o sim_prbs
	./obj_dir/sim_prbs | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: boot_sequencer/boot_sequencer.sv
`timescale 1ns/1ps

module boot_sequencer
    import prbs_test_pkg::*;
#(
    parameter int unsigned TX_WAIT    = 20,
    parameter int unsigned RX_WAIT    = 40,
    parameter int unsigned INJECT_END = 140,
    parameter int unsigned HOLD_END   = 160,
    parameter int unsigned CLEAR_END  = 180
) (
    input  logic          clk40,
    input  logic          PRBS_reset,
    input  logic          reset_req_i,
    input  logic          resync_i,
    input  logic          bx0_i,
    input  logic          bxreset_i,
    input  logic          inject_i,
    input  lane_mask_t    tx_reset_done_i,
    input  lane_mask_t    rx_reset_done_i,
    input  lane_mask_t    prbs_error_i,
    input  display_mask_t lane_led_i,
    output lane_mask_t    tx_reset_o,
    output lane_mask_t    rx_reset_o,
    output logic          prbs_cnt_reset_o,
    output logic          err_count_clear_o,
    output logic          force_err_o,
    output led_t          led_fp_o
);

    seq_state_t    state;
    seq_state_t    next_state;
    step_count_t   step_cnt;
    logic          timer_clear;
    status_code_t  status_code;
    display_mask_t led_low;

    ////////////////////////////////////////////////////////////////////////////
    // State register and step timer
    ////////////////////////////////////////////////////////////////////////////

    // Button reset and resync restart the sequence synchronously
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            state <= RESET;
        end else if (reset_req_i || resync_i) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    // Timer runs through the timed steps, and the three injection steps share one count
    assign timer_clear = state inside {RESET, EN_TX_DONE, EN_RX_DONE, EN_PRBS_CK};

    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            step_cnt <= '0;
        end else if (timer_clear) begin
            step_cnt <= '0;
        end else begin
            step_cnt <= step_cnt + step_count_t'(1);
        end
    end

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            RESET: next_state = EN_TX;
            EN_TX: begin
                if (step_cnt >= step_count_t'(TX_WAIT)) next_state = EN_TX_DONE;
            end
            EN_TX_DONE: begin
                // Every transmitter must report reset done
                if (&tx_reset_done_i) next_state = EN_RX;
            end
            EN_RX: begin
                if (step_cnt >= step_count_t'(RX_WAIT)) next_state = EN_RX_DONE;
            end
            EN_RX_DONE: begin
                if (&rx_reset_done_i) next_state = PRBS_INJECT;
            end
            PRBS_INJECT: begin
                if (step_cnt >= step_count_t'(INJECT_END)) next_state = PRBS_INJECT_DONE;
            end
            PRBS_INJECT_DONE: begin
                if (step_cnt >= step_count_t'(HOLD_END)) next_state = PRBS_INJECT_CLEAR;
            end
            PRBS_INJECT_CLEAR: begin
                if (step_cnt >= step_count_t'(CLEAR_END)) next_state = EN_PRBS_CK;
            end
            // Checking mode holds until a restart
            EN_PRBS_CK: next_state = EN_PRBS_CK;
            default: next_state = RESET;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output decode from state and live inputs
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        tx_reset_o        = '0;
        rx_reset_o        = '0;
        prbs_cnt_reset_o  = 1'b0;
        err_count_clear_o = 1'b1;
        force_err_o       = 1'b0;
        status_code       = LED_RESET;
        led_low           = '0;
        case (state)
            RESET: begin
                tx_reset_o = '1;
                rx_reset_o = '1;
            end
            EN_TX: begin
                rx_reset_o  = '1;
                status_code = LED_EN_TX;
            end
            EN_TX_DONE: begin
                rx_reset_o  = '1;
                status_code = LED_EN_TX_DONE;
            end
            EN_RX: status_code = LED_EN_RX;
            EN_RX_DONE: begin
                // Forcing starts early so the first injected word is not missed
                force_err_o = 1'b1;
                status_code = LED_EN_RX_DONE;
            end
            PRBS_INJECT: begin
                force_err_o       = 1'b1;
                err_count_clear_o = 1'b0;
                status_code       = LED_PRBS_INJECT;
                led_low           = prbs_error_i[NUM_LANES-1 -: NUM_DISPLAY_LANES];
            end
            PRBS_INJECT_DONE: begin
                prbs_cnt_reset_o = 1'b1;
                status_code      = LED_PRBS_INJECT_DONE;
                led_low          = prbs_error_i[NUM_LANES-1 -: NUM_DISPLAY_LANES];
            end
            PRBS_INJECT_CLEAR: begin
                status_code = LED_PRBS_INJECT_CLEAR;
                led_low     = prbs_error_i[NUM_LANES-1 -: NUM_DISPLAY_LANES];
            end
            EN_PRBS_CK: begin
                // Button level or bx0 command forces errors, bxreset clears counts
                force_err_o       = inject_i | bx0_i;
                prbs_cnt_reset_o  = bxreset_i;
                err_count_clear_o = bxreset_i;
                status_code       = LED_EN_PRBS_CK;
                led_low           = lane_led_i;
            end
            default: begin
                tx_reset_o = '1;
                rx_reset_o = '1;
            end
        endcase
    end

    assign led_fp_o = {status_code, led_low};

endmodule

// File: build.f
common/prbs_test_pkg.sv
source/ccb_cmd_decoder.sv
source/button_debouncer.sv
boot_sequencer/boot_sequencer.sv
error_monitor/lane_error_counter.sv
error_monitor/error_monitor.sv
source/prbs_test_top.sv
test/tb_prbs_test_top.sv

// File: common/prbs_test_pkg.sv
package prbs_test_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Lane counts and vector types
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_LANES         = 8;
    // Monitored lanes sit in the upper half
    localparam int NUM_DISPLAY_LANES = 4;

    typedef logic [NUM_LANES-1:0]         lane_mask_t;
    typedef logic [NUM_DISPLAY_LANES-1:0] display_mask_t;
    typedef logic [7:0]                   led_t;
    typedef logic [3:0]                   status_code_t;
    typedef logic [50:0]                  ccb_word_t;
    typedef logic [5:0]                   ccb_cmd_t;
    typedef logic [15:0]                  step_count_t;

    // Boot and test sequence, in order of progress
    typedef enum logic [3:0] {
        RESET, EN_TX, EN_TX_DONE, EN_RX, EN_RX_DONE,
        PRBS_INJECT, PRBS_INJECT_DONE, PRBS_INJECT_CLEAR, EN_PRBS_CK
    } seq_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // CCB bus layout and command codes
    ////////////////////////////////////////////////////////////////////////////

    localparam int CCB_CMD_LSB    = 2;
    localparam int CCB_STROBE_BIT = 10;
    // Two unused bits that are not inverted on the bus
    localparam int CCB_GAP_LSB    = 34;
    localparam int CCB_GAP_MSB    = 35;

    localparam ccb_cmd_t CMD_BX0     = 6'h01;
    localparam ccb_cmd_t CMD_RESYNC  = 6'h03;
    localparam ccb_cmd_t CMD_BXRESET = 6'h32;

    // Upper LED nibble per sequencer state
    localparam status_code_t LED_RESET             = 4'h1;
    localparam status_code_t LED_EN_TX             = 4'h2;
    localparam status_code_t LED_EN_TX_DONE        = 4'h3;
    localparam status_code_t LED_EN_RX             = 4'h4;
    localparam status_code_t LED_EN_RX_DONE        = 4'h5;
    localparam status_code_t LED_PRBS_INJECT       = 4'h6;
    localparam status_code_t LED_PRBS_INJECT_DONE  = 4'h8;
    localparam status_code_t LED_PRBS_INJECT_CLEAR = 4'h7;
    localparam status_code_t LED_EN_PRBS_CK        = 4'hF;

endpackage

// File: error_monitor/error_monitor.sv
`timescale 1ns/1ps

module error_monitor
    import prbs_test_pkg::*;
#(
    parameter int BLINK_HALF_PERIOD = 8
) (
    input  logic          clk40,
    input  logic          PRBS_reset,
    input  lane_mask_t    prbs_error_i,
    input  logic          latch_clear_i,
    input  logic          count_clear_i,
    output lane_mask_t    latched_error_o,
    output display_mask_t lane_led_o
);

    localparam int BLINK_W = $clog2(BLINK_HALF_PERIOD + 1);

    logic [BLINK_W-1:0] blink_cnt;
    logic               blink;

    // Sticky error flags for all lanes
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            latched_error_o <= '0;
        end else if (latch_clear_i) begin
            latched_error_o <= '0;
        end else begin
            latched_error_o <= latched_error_o | prbs_error_i;
        end
    end

    // Free running blinker shared by all lane displays
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            blink_cnt <= '0;
            blink     <= 1'b0;
        end else if (blink_cnt == BLINK_W'(BLINK_HALF_PERIOD - 1)) begin
            blink_cnt <= '0;
            blink     <= ~blink;
        end else begin
            blink_cnt <= blink_cnt + BLINK_W'(1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // One display counter per monitored lane
    ////////////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < NUM_DISPLAY_LANES; i++) begin : g_lane
        lane_error_counter u_lane_counter (
            .clk40      (clk40),
            .PRBS_reset (PRBS_reset),
            .error_i    (prbs_error_i[NUM_LANES - NUM_DISPLAY_LANES + i]),
            .clear_i    (count_clear_i),
            .blink_i    (blink),
            .led_o      (lane_led_o[i])
        );
    end

endmodule

// File: error_monitor/lane_error_counter.sv
`timescale 1ns/1ps

module lane_error_counter (
    input  logic clk40,
    input  logic PRBS_reset,
    input  logic error_i,
    input  logic clear_i,
    input  logic blink_i,
    output logic led_o
);

    logic [1:0] err_cnt;

    // Count of error cycles, stops at three
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            err_cnt <= '0;
        end else if (clear_i) begin
            err_cnt <= '0;
        end else if (error_i && (err_cnt != 2'd3)) begin
            err_cnt <= err_cnt + 2'd1;
        end
    end

    // Off when clean, steady for a few errors, blinking when saturated
    always_comb begin
        case (err_cnt)
            2'd0: begin
                led_o = 1'b0;
            end
            2'd3: begin
                led_o = blink_i;
            end
            default: begin
                led_o = 1'b1;
            end
        endcase
    end

endmodule

// File: source/button_debouncer.sv
`timescale 1ns/1ps

module button_debouncer #(
    parameter int DEBOUNCE_CYCLES = 4
) (
    input  logic clk40,
    input  logic PRBS_reset,
    input  logic btn_i,
    output logic level_o
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [1:0]       btn_sync;
    logic [CNT_W-1:0] diff_cnt;

    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            btn_sync <= '0;
            diff_cnt <= '0;
            level_o  <= 1'b0;
        end else begin
            // Two flops bring the front-panel pin into clk40
            btn_sync <= {btn_sync[0], btn_i};
            if (btn_sync[1] == level_o) begin
                // Any bounce back restarts the count
                diff_cnt <= '0;
            end else if (diff_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                diff_cnt <= '0;
                level_o  <= btn_sync[1];
            end else begin
                diff_cnt <= diff_cnt + CNT_W'(1);
            end
        end
    end

endmodule

// File: source/ccb_cmd_decoder.sv
`timescale 1ns/1ps

module ccb_cmd_decoder
    import prbs_test_pkg::*;
(
    input  logic      clk40,
    input  logic      PRBS_reset,
    input  ccb_word_t ccb_rx_i,
    output logic      bx0_o,
    output logic      resync_o,
    output logic      bxreset_o
);

    ccb_word_t ccb_reg;
    ccb_word_t ccb_fixed;
    ccb_cmd_t  ccb_cmd;
    logic      ccb_strobe;

    // Input register stage for the raw bus
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            // Idle bus is all ones, so the fixed word starts at zero
            ccb_reg <= '1;
        end else begin
            ccb_reg <= ccb_rx_i;
        end
    end

    // Bus is active low everywhere except the gap
    always_comb begin
        ccb_fixed = ~ccb_reg;
        ccb_fixed[CCB_GAP_MSB:CCB_GAP_LSB] = '0;
    end

    // Command field and strobe
    assign ccb_cmd    = ccb_fixed[CCB_CMD_LSB +: $bits(ccb_cmd_t)];
    assign ccb_strobe = ccb_fixed[CCB_STROBE_BIT];

    ////////////////////////////////////////////////////////////////////////////
    // Registered decode, one pulse per held cycle
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk40 or posedge PRBS_reset) begin
        if (PRBS_reset) begin
            bx0_o     <= 1'b0;
            resync_o  <= 1'b0;
            bxreset_o <= 1'b0;
        end else begin
            bx0_o     <= ccb_strobe && (ccb_cmd == CMD_BX0);
            resync_o  <= ccb_strobe && (ccb_cmd == CMD_RESYNC);
            bxreset_o <= ccb_strobe && (ccb_cmd == CMD_BXRESET);
        end
    end

endmodule

// File: source/prbs_test_top.sv
`timescale 1ns/1ps

module prbs_test_top
    import prbs_test_pkg::*;
#(
    parameter int          DEBOUNCE_CYCLES   = 4,
    parameter int          BLINK_HALF_PERIOD = 8,
    parameter int unsigned TX_WAIT           = 20,
    parameter int unsigned RX_WAIT           = 40,
    parameter int unsigned INJECT_END        = 140,
    parameter int unsigned HOLD_END          = 160,
    parameter int unsigned CLEAR_END         = 180
) (
    input  logic       clk40,
    input  logic       PRBS_reset,
    input  logic       reset_btn_i,
    input  logic       inject_btn_i,
    input  ccb_word_t  ccb_rx_i,
    input  lane_mask_t tx_reset_done_i,
    input  lane_mask_t rx_reset_done_i,
    input  lane_mask_t prbs_error_i,
    output lane_mask_t tx_reset_o,
    output lane_mask_t rx_reset_o,
    output logic       prbs_cnt_reset_o,
    output logic       force_err_o,
    output led_t       led_fp_o,
    output lane_mask_t latched_error_o
);

    logic          bx0;
    logic          resync;
    logic          bxreset;
    logic          reset_level;
    logic          inject_level;
    logic          err_count_clear;
    display_mask_t lane_led;

    ////////////////////////////////////////////////////////////////////////////
    // Command decode and front-panel buttons
    ////////////////////////////////////////////////////////////////////////////
    ccb_cmd_decoder u_ccb_cmd_decoder (
        .clk40      (clk40),
        .PRBS_reset (PRBS_reset),
        .ccb_rx_i   (ccb_rx_i),
        .bx0_o      (bx0),
        .resync_o   (resync),
        .bxreset_o  (bxreset)
    );

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) reset_debounce (
        .clk40 (clk40), .PRBS_reset (PRBS_reset), .btn_i (reset_btn_i), .level_o (reset_level)
    );

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) inject_debounce (
        .clk40 (clk40), .PRBS_reset (PRBS_reset), .btn_i (inject_btn_i), .level_o (inject_level)
    );

    // Sequencer drives the transceiver controls and the LED byte
    boot_sequencer #(
        .TX_WAIT    (TX_WAIT),
        .RX_WAIT    (RX_WAIT),
        .INJECT_END (INJECT_END),
        .HOLD_END   (HOLD_END),
        .CLEAR_END  (CLEAR_END)
    ) u_boot_sequencer (
        .clk40             (clk40),
        .PRBS_reset        (PRBS_reset),
        .reset_req_i       (reset_level),
        .resync_i          (resync),
        .bx0_i             (bx0),
        .bxreset_i         (bxreset),
        .inject_i          (inject_level),
        .tx_reset_done_i   (tx_reset_done_i),
        .rx_reset_done_i   (rx_reset_done_i),
        .prbs_error_i      (prbs_error_i),
        .lane_led_i        (lane_led),
        .tx_reset_o        (tx_reset_o),
        .rx_reset_o        (rx_reset_o),
        .prbs_cnt_reset_o  (prbs_cnt_reset_o),
        .err_count_clear_o (err_count_clear),
        .force_err_o       (force_err_o),
        .led_fp_o          (led_fp_o)
    );

    // Latch clears with the PRBS counter reset, displays with the count clear
    error_monitor #(.BLINK_HALF_PERIOD(BLINK_HALF_PERIOD)) u_error_monitor (
        .clk40           (clk40),
        .PRBS_reset      (PRBS_reset),
        .prbs_error_i    (prbs_error_i),
        .latch_clear_i   (prbs_cnt_reset_o),
        .count_clear_i   (err_count_clear),
        .latched_error_o (latched_error_o),
        .lane_led_o      (lane_led)
    );

endmodule

// File: test/tb_prbs_test_top.sv
`timescale 1ns/1ps

module tb_prbs_test_top
    import prbs_test_pkg::*;
();

    localparam int DEBOUNCE_CYCLES   = 4;
    localparam int BLINK_HALF_PERIOD = 8;
    localparam int TX_WAIT           = 20;
    localparam int RX_WAIT           = 40;
    localparam int INJECT_END        = 140;
    localparam int HOLD_END          = 160;
    localparam int CLEAR_END         = 180;
    // Transceiver model delays from reset release to reset done
    localparam int TX_DONE_DELAY     = 6;
    localparam int RX_DONE_DELAY     = 9;
    localparam int NUM_TESTS         = 5;
    localparam int TIMEOUT_CYCLES    = 3 * (CLEAR_END + DEBOUNCE_CYCLES + 2 * BLINK_HALF_PERIOD
                                       + TX_DONE_DELAY + RX_DONE_DELAY) * NUM_TESTS;
    localparam int BOOT_LIMIT        = CLEAR_END + TX_WAIT + RX_WAIT + TX_DONE_DELAY
                                       + RX_DONE_DELAY + 2 * DEBOUNCE_CYCLES + 20;
    localparam ccb_word_t CCB_IDLE   = '1;

    logic       clk40;
    logic       PRBS_reset;
    logic       reset_btn_i;
    logic       inject_btn_i;
    ccb_word_t  ccb_rx_i;
    lane_mask_t tx_reset_done_i = '0;
    lane_mask_t rx_reset_done_i = '0;
    lane_mask_t prbs_error_i;
    lane_mask_t tx_reset_o;
    lane_mask_t rx_reset_o;
    logic       prbs_cnt_reset_o;
    logic       force_err_o;
    led_t       led_fp_o;
    lane_mask_t latched_error_o;

    lane_mask_t tx_stuck;
    lane_mask_t rx_stuck;
    int         tx_wait_cnt = 0;
    int         rx_wait_cnt = 0;
    int         checks = 0;
    int         errors = 0;
    int         cycle_count;

    prbs_test_top #(
        .DEBOUNCE_CYCLES   (DEBOUNCE_CYCLES),
        .BLINK_HALF_PERIOD (BLINK_HALF_PERIOD),
        .TX_WAIT           (TX_WAIT),
        .RX_WAIT           (RX_WAIT),
        .INJECT_END        (INJECT_END),
        .HOLD_END          (HOLD_END),
        .CLEAR_END         (CLEAR_END)
    ) DUT (
        .clk40            (clk40),
        .PRBS_reset       (PRBS_reset),
        .reset_btn_i      (reset_btn_i),
        .inject_btn_i     (inject_btn_i),
        .ccb_rx_i         (ccb_rx_i),
        .tx_reset_done_i  (tx_reset_done_i),
        .rx_reset_done_i  (rx_reset_done_i),
        .prbs_error_i     (prbs_error_i),
        .tx_reset_o       (tx_reset_o),
        .rx_reset_o       (rx_reset_o),
        .prbs_cnt_reset_o (prbs_cnt_reset_o),
        .force_err_o      (force_err_o),
        .led_fp_o         (led_fp_o),
        .latched_error_o  (latched_error_o)
    );

    initial begin
        clk40 = 1'b0;
        forever #50 clk40 = ~clk40;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Transceiver model
    ////////////////////////////////////////////////////////////////////////////

    // Done flags rise a fixed delay after the reset outputs all drop
    always @(negedge clk40) begin
        if (tx_reset_o != '0) begin
            tx_wait_cnt     <= 0;
            tx_reset_done_i <= '0;
        end else if (tx_wait_cnt < TX_DONE_DELAY) begin
            tx_wait_cnt <= tx_wait_cnt + 1;
        end else begin
            // Stuck lanes never report done
            tx_reset_done_i <= ~tx_stuck;
        end
    end

    always @(negedge clk40) begin
        if (rx_reset_o != '0) begin
            rx_wait_cnt     <= 0;
            rx_reset_done_i <= '0;
        end else if (rx_wait_cnt < RX_DONE_DELAY) begin
            rx_wait_cnt <= rx_wait_cnt + 1;
        end else begin
            rx_reset_done_i <= ~rx_stuck;
        end
    end

    // Run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk40);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles without finishing", cycle_count);
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks and helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_led(input string name, input led_t got, input led_t exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_lanes(input string name, input lane_mask_t got, input lane_mask_t exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic step(input int n);
        repeat (n) @(negedge clk40);
    endtask

    // Active-low bus with strobe and command, gap bits are don't care
    function automatic ccb_word_t ccb_word(input ccb_cmd_t cmd, input logic strobe);
        ccb_word_t w;
        w = '0;
        w[CCB_CMD_LSB +: $bits(ccb_cmd_t)] = cmd;
        w[CCB_STROBE_BIT] = strobe;
        w = ~w;
        w[CCB_GAP_MSB:CCB_GAP_LSB] = 2'($urandom);
        return w;
    endfunction

    task automatic wait_code(input status_code_t code, input int limit);
        int n;
        n = 0;
        while (led_fp_o[7:4] !== code && n < limit) begin
            @(negedge clk40);
            n++;
        end
        if (led_fp_o[7:4] !== code) begin
            $display("LED state code %h was not reached within %0d cycles", code, limit);
            errors++;
        end
    endtask

    task automatic wait_force(input logic level, input int limit);
        int n;
        n = 0;
        while (force_err_o !== level && n < limit) begin
            @(negedge clk40);
            n++;
        end
        if (force_err_o !== level) begin
            $display("force_err_o did not go to %b within %0d cycles", level, limit);
            errors++;
        end
    endtask

    task automatic pulse_errors(input lane_mask_t lanes, input int cycles);
        repeat (cycles) begin
            prbs_error_i = lanes;
            @(negedge clk40);
        end
        prbs_error_i = '0;
    endtask

    // Word held for hold cycles, force seen from the second sample on
    task automatic force_from_ccb(input string name, input ccb_word_t word, input int hold,
                                  input logic expect_pulse);
        for (int i = 0; i < hold + 5; i++) begin
            ccb_rx_i = (i < hold) ? word : CCB_IDLE;
            @(negedge clk40);
            check_bit(name, force_err_o, expect_pulse && (i >= 1) && (i <= hold));
        end
        ccb_rx_i = CCB_IDLE;
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%-18s finished, %0d errors", name, errors - errors_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic boot_order();
        int e0;
        e0 = errors;
        // One lane each side held back to see the sequencer wait
        tx_stuck <= 8'h04;
        rx_stuck <= 8'h40;
        step(5);
        PRBS_reset = 1'b0;
        check_led("led_fp_o after reset", led_fp_o, 8'h10);
        check_lanes("tx_reset_o after reset", tx_reset_o, 8'hFF);
        check_lanes("rx_reset_o after reset", rx_reset_o, 8'hFF);
        wait_code(4'h2, 4);
        check_lanes("tx_reset_o in EN_TX", tx_reset_o, 8'h00);
        check_lanes("rx_reset_o in EN_TX", rx_reset_o, 8'hFF);
        wait_code(4'h3, TX_WAIT + 5);
        step(3 * TX_DONE_DELAY);
        check_led("led_fp_o with tx lane stuck", led_fp_o, 8'h30);
        tx_stuck <= '0;
        wait_code(4'h4, TX_DONE_DELAY + 5);
        check_lanes("rx_reset_o in EN_RX", rx_reset_o, 8'h00);
        wait_code(4'h5, RX_WAIT + 5);
        step(3 * RX_DONE_DELAY);
        check_led("led_fp_o with rx lane stuck", led_fp_o, 8'h50);
        report_test("boot order", e0);
    endtask

    task automatic injection_window();
        int e0;
        e0 = errors;
        check_bit("force_err_o at code 5", force_err_o, 1'b1);
        check_bit("prbs_cnt_reset_o at code 5", prbs_cnt_reset_o, 1'b0);
        rx_stuck <= '0;
        wait_code(4'h6, RX_DONE_DELAY + 5);
        check_bit("force_err_o at code 6", force_err_o, 1'b1);
        check_bit("prbs_cnt_reset_o at code 6", prbs_cnt_reset_o, 1'b0);
        prbs_error_i = 8'hA3;
        step(1);
        check_led("led_fp_o mirror at code 6", led_fp_o, 8'h6A);
        prbs_error_i = '0;
        wait_code(4'h8, INJECT_END + 5);
        check_bit("force_err_o at code 8", force_err_o, 1'b0);
        check_bit("prbs_cnt_reset_o at code 8", prbs_cnt_reset_o, 1'b1);
        prbs_error_i = 8'h5C;
        step(1);
        check_led("led_fp_o mirror at code 8", led_fp_o, 8'h85);
        prbs_error_i = '0;
        wait_code(4'h7, HOLD_END - INJECT_END + 5);
        check_bit("force_err_o at code 7", force_err_o, 1'b0);
        check_bit("prbs_cnt_reset_o at code 7", prbs_cnt_reset_o, 1'b0);
        prbs_error_i = 8'h30;
        step(1);
        check_led("led_fp_o mirror at code 7", led_fp_o, 8'h73);
        prbs_error_i = '0;
        wait_code(4'hF, CLEAR_END - HOLD_END + 5);
        check_bit("prbs_cnt_reset_o at code F", prbs_cnt_reset_o, 1'b0);
        report_test("injection window", e0);
    endtask

    task automatic lane_display();
        int   e0;
        logic saw_low;
        logic saw_high;
        e0 = errors;
        saw_low = 1'b0;
        saw_high = 1'b0;
        // Start from a clean latch and clean counters
        ccb_rx_i = ccb_word(CMD_BXRESET, 1'b1);
        step(1);
        ccb_rx_i = CCB_IDLE;
        step(4);
        check_lanes("latched_error_o after bxreset", latched_error_o, 8'h00);
        check_led("led_fp_o with no errors", led_fp_o, 8'hF0);
        pulse_errors(8'h10, 1);
        check_led("led_fp_o after one lane 4 error", led_fp_o, 8'hF1);
        pulse_errors(8'h20, 2);
        check_led("led_fp_o after two lane 5 errors", led_fp_o, 8'hF3);
        pulse_errors(8'h05, 1);
        check_lanes("latched_error_o after lanes 0 2 4 5", latched_error_o, 8'h35);
        pulse_errors(8'h80, 3);
        for (int i = 0; i < 2 * BLINK_HALF_PERIOD + 2; i++) begin
            if (led_fp_o[3]) saw_high = 1'b1;
            else saw_low = 1'b1;
            step(1);
        end
        check_bit("lane 7 display toggles", saw_low & saw_high, 1'b1);
        check_led("led_fp_o steady lanes", led_fp_o & 8'hF7, 8'hF3);
        check_lanes("latched_error_o after lane 7", latched_error_o, 8'hB5);
        ccb_rx_i = ccb_word(CMD_BXRESET, 1'b1);
        step(1);
        ccb_rx_i = CCB_IDLE;
        step(4);
        check_lanes("latched_error_o cleared", latched_error_o, 8'h00);
        check_led("led_fp_o cleared", led_fp_o, 8'hF0);
        report_test("lane display", e0);
    endtask

    task automatic inject_command();
        int e0;
        e0 = errors;
        force_from_ccb("force_err_o from bx0", ccb_word(CMD_BX0, 1'b1), 3, 1'b1);
        force_from_ccb("force_err_o bx0 no strobe", ccb_word(CMD_BX0, 1'b0), 3, 1'b0);
        inject_btn_i = 1'b1;
        wait_force(1'b1, 2 * DEBOUNCE_CYCLES + 4);
        repeat (5) begin
            step(1);
            check_bit("force_err_o while inject held", force_err_o, 1'b1);
        end
        inject_btn_i = 1'b0;
        wait_force(1'b0, 2 * DEBOUNCE_CYCLES + 4);
        // Too short to pass the debouncer
        inject_btn_i = 1'b1;
        step(DEBOUNCE_CYCLES - 1);
        inject_btn_i = 1'b0;
        repeat (2 * DEBOUNCE_CYCLES + 4) begin
            step(1);
            check_bit("force_err_o after inject glitch", force_err_o, 1'b0);
        end
        report_test("inject command", e0);
    endtask

    task automatic restart();
        int e0;
        e0 = errors;
        reset_btn_i = 1'b1;
        step(DEBOUNCE_CYCLES - 1);
        reset_btn_i = 1'b0;
        repeat (2 * DEBOUNCE_CYCLES + 4) begin
            step(1);
            check_led("led_fp_o after reset glitch", led_fp_o & 8'hF0, 8'hF0);
        end
        ccb_rx_i = ccb_word(CMD_RESYNC, 1'b1);
        step(1);
        ccb_rx_i = CCB_IDLE;
        wait_code(4'h1, 4);
        check_led("led_fp_o after resync", led_fp_o, 8'h10);
        check_lanes("tx_reset_o after resync", tx_reset_o, 8'hFF);
        check_lanes("rx_reset_o after resync", rx_reset_o, 8'hFF);
        wait_code(4'hF, BOOT_LIMIT);
        // Random bounce, then a steady press
        repeat (8) begin
            reset_btn_i = 1'($urandom);
            step(1);
        end
        reset_btn_i = 1'b1;
        step(2 * DEBOUNCE_CYCLES + 4);
        check_led("led_fp_o after reset button", led_fp_o, 8'h10);
        check_lanes("tx_reset_o after reset button", tx_reset_o, 8'hFF);
        check_lanes("rx_reset_o after reset button", rx_reset_o, 8'hFF);
        reset_btn_i = 1'b0;
        report_test("restart", e0);
    endtask

    initial begin
        void'($urandom(32'ha44fffc9));
        PRBS_reset   = 1'b1;
        reset_btn_i  = 1'b0;
        inject_btn_i = 1'b0;
        ccb_rx_i     = CCB_IDLE;
        prbs_error_i = '0;
        boot_order();
        injection_window();
        lane_display();
        inject_command();
        restart();
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
